// ==== Bender.yml ====
package:
  name: ise_coproc

sources:
  - source/ise_pkg.sv
  - source/ise_decoder.sv
  - source/cpr_file.sv
  - source/ise_exec.sv
  - source/ise_top.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/tb_clock.sv
      - tests/tb_ise.sv

// ==== sim.f ====
+incdir+tests
source/ise_pkg.sv
source/ise_decoder.sv
source/cpr_file.sv
source/ise_exec.sv
source/ise_top.sv
tests/tb_clock.sv
tests/tb_ise.sv

// ==== source/cpr_file.sv ====
`timescale 1ns/1ns

module cpr_file (
    input                      g_clk,
    input                      g_resetn,
    input  ise_pkg::cpr_addr_t raddr_a,     // crs1
    input  ise_pkg::cpr_addr_t raddr_b,     // crs2
    input  ise_pkg::cpr_addr_t raddr_c,     // crd, read-modify-write ops
    output ise_pkg::word_t     rdata_a,
    output ise_pkg::word_t     rdata_b,
    output ise_pkg::word_t     rdata_c,
    input                      wen,         // Already qualified by accept
    input  ise_pkg::cpr_addr_t waddr,
    input  ise_pkg::word_t     wdata
);

    import ise_pkg::*;

    word_t cprs [NUM_CPRS];

    // Single write port, all registers cleared on reset
    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            cprs <= '{default: '0};
        end
        else if (wen)
        begin
            cprs[waddr] <= wdata;
        end
    end

    // Asynchronous reads
    assign rdata_a = cprs[raddr_a];
    assign rdata_b = cprs[raddr_b];
    assign rdata_c = cprs[raddr_c];

endmodule

// ==== source/ise_decoder.sv ====
`timescale 1ns/1ns

module ise_decoder (
    input  ise_pkg::word_t    insn_enc,   // Raw instruction from the core
    output ise_pkg::ise_uop_t uop         // Decoded fields
);

    import ise_pkg::*;

    // ------------------------------
    // Opcode and function checks
    // ------------------------------

    opcode_t                   opcode;
    logic [$bits(ise_op_e)-1:0] funct;
    logic                      opcode_ok;
    logic                      funct_ok;

    assign opcode    = insn_enc[$bits(opcode_t)-1:0];
    assign funct     = insn_enc[FUNCT_LSB +: $bits(ise_op_e)];
    assign opcode_ok = (opcode == ISE_OPCODE);
    assign funct_ok  = (funct <= OP_BOP);     // Codes above bop are reserved

    // ------------------------------
    // Field extraction
    // ------------------------------

    always_comb
    begin
        uop.valid_op = opcode_ok && funct_ok;
        uop.op       = ise_op_e'(funct);      // Meaningless when valid_op is low

        // Register indices
        uop.rd       = insn_enc[RD_LSB   +: $bits(gpr_addr_t)];
        uop.crs1     = insn_enc[CRS1_LSB +: $bits(cpr_addr_t)];
        uop.crs2     = insn_enc[CRS2_LSB +: $bits(cpr_addr_t)];

        // Immediates, which overlap between formats
        uop.imm16    = insn_enc[IMM_LSB +: $bits(imm16_t)];
        uop.lut      = insn_enc[LUT_LSB +: $bits(lut_t)];

        // cs and cl count pairs of bits, so shift in a zero
        uop.start    = {insn_enc[CS_LSB +: $bits(bitpos_t)-1], 1'b0};
        uop.len      = {insn_enc[CL_LSB +: $bits(bitpos_t)-1], 1'b0};
    end

endmodule

// ==== source/ise_exec.sv ====
`timescale 1ns/1ns

module ise_exec (
    input  ise_pkg::ise_uop_t  uop,
    input  ise_pkg::word_t     rs1,         // GPR operand from the core
    input  ise_pkg::word_t     crs1_data,
    input  ise_pkg::word_t     crs2_data,
    input  ise_pkg::word_t     crd_data,    // Old crd value
    output logic               cpr_wen,     // Top gates this with accept
    output ise_pkg::word_t     cpr_wdata,
    output ise_pkg::ise_resp_t resp
);

    import ise_pkg::*;

    // ------------------------------
    // Datapath helpers
    // ------------------------------

    word_t field_mask;      // len ones at the bottom
    word_t ins_mask;
    word_t ins_data;
    word_t ext_data;
    word_t bop_data;
    logic  crs2_zero;

    assign field_mask = ~(word_t'('1) << uop.len);
    assign ins_mask   = field_mask << uop.start;
    assign ins_data   = (ins_mask & (crs1_data << uop.start)) | (~ins_mask & crd_data);
    assign ext_data   = (crs1_data >> uop.start) & field_mask;
    assign crs2_zero  = (crs2_data == '0);

    // Each bit picks one lut entry, crs1 is the index MSB
    always_comb
    begin
        for (int i = 0; i < $bits(word_t); i++)
        begin
            bop_data[i] = uop.lut[{crs1_data[i], crs2_data[i]}];
        end
    end

    // ------------------------------
    // Op select
    // ------------------------------

    always_comb
    begin
        cpr_wen        = 1'b0;
        cpr_wdata      = crd_data;
        resp           = '0;
        resp.result    = RES_SUCCESS;

        if (!uop.valid_op)
        begin
            resp.result = RES_DECODE_EXCEPTION;     // No CPR or GPR write
        end
        else
        begin
            case (uop.op)
                OP_MV2GPR:
                begin
                    resp.rd_wen  = 1'b1;
                    resp.rd_addr = uop.rd;
                    resp.rd_data = crs1_data;
                end
                OP_MV2COP:
                begin
                    cpr_wen   = 1'b1;
                    cpr_wdata = rs1;
                end
                OP_CMOV:  begin cpr_wen = crs2_zero;  cpr_wdata = crs1_data; end
                OP_CMOVN: begin cpr_wen = !crs2_zero; cpr_wdata = crs1_data; end
                OP_LUI:   begin cpr_wen = 1'b1; cpr_wdata = {uop.imm16, crd_data[15:0]}; end
                OP_LLI:   begin cpr_wen = 1'b1; cpr_wdata = {crd_data[31:16], uop.imm16}; end
                OP_INS:   begin cpr_wen = 1'b1; cpr_wdata = ins_data; end
                OP_EXT:   begin cpr_wen = 1'b1; cpr_wdata = ext_data; end
                OP_BOP:   begin cpr_wen = 1'b1; cpr_wdata = bop_data; end
                default:  resp.result = RES_DECODE_EXCEPTION;   // valid_op excludes this
            endcase
        end
    end

endmodule

// ==== source/ise_pkg.sv ====
package ise_pkg;

// ------------------------------
// Widths with a meaning
// ------------------------------

typedef logic [31:0] word_t;        // CPR and GPR data word
typedef logic [ 3:0] cpr_addr_t;    // One of the sixteen CPRs
typedef logic [ 4:0] gpr_addr_t;    // Core general register index
typedef logic [ 6:0] opcode_t;      // RISC-V major opcode
typedef logic [15:0] imm16_t;       // lui / lli immediate
typedef logic [ 4:0] bitpos_t;      // Even bit position or field length
typedef logic [ 3:0] lut_t;         // bop truth table

localparam int NUM_CPRS = 16;

// ------------------------------
// Instruction encoding
// ------------------------------

localparam opcode_t ISE_OPCODE = 7'b0001011;    // custom-0 slot

// LSB of each field inside the 32-bit instruction
localparam int FUNCT_LSB = 28;      // Function code, bits 31:28
localparam int RD_LSB    = 7;       // rd / crd, bits 11:7
localparam int CRS1_LSB  = 16;      // bits 19:16
localparam int CRS2_LSB  = 20;      // bits 23:20
localparam int IMM_LSB   = 12;      // 16-bit immediate, bits 27:12
localparam int CS_LSB    = 24;      // ins/ext start / 2
localparam int CL_LSB    = 12;      // ins/ext length / 2
localparam int LUT_LSB   = 24;      // bop table

// Function codes, 9 to 15 are reserved
typedef enum logic [3:0] {
    OP_MV2GPR = 4'd0,
    OP_MV2COP = 4'd1,
    OP_CMOV   = 4'd2,
    OP_CMOVN  = 4'd3,
    OP_LUI    = 4'd4,
    OP_LLI    = 4'd5,
    OP_INS    = 4'd6,
    OP_EXT    = 4'd7,
    OP_BOP    = 4'd8
} ise_op_e;

typedef enum logic [2:0] {
    RES_SUCCESS          = 3'b000,
    RES_DECODE_EXCEPTION = 3'b010
} ise_result_e;

// ------------------------------
// Bundles
// ------------------------------

typedef struct packed {
    logic      valid_op;    // Opcode and function code both recognised
    ise_op_e   op;
    gpr_addr_t rd;          // Low 4 bits double as crd
    cpr_addr_t crs1;
    cpr_addr_t crs2;
    imm16_t    imm16;
    bitpos_t   start;       // Already doubled
    bitpos_t   len;         // Already doubled
    lut_t      lut;
} ise_uop_t;

typedef struct packed {
    ise_result_e result;
    logic        rd_wen;
    gpr_addr_t   rd_addr;
    word_t       rd_data;
} ise_resp_t;

typedef struct packed {
    word_t insn_enc;
    word_t rs1;
} ise_req_t;

endpackage

// ==== source/ise_top.sv ====
`timescale 1ns/1ns

module ise_top (
    input                      g_clk,
    input                      g_resetn,

    // Request channel from the core
    input                      req_valid,
    input  ise_pkg::ise_req_t  req,
    output logic               req_ready,

    // Response channel to the core
    output logic               rsp_valid,
    output ise_pkg::ise_resp_t rsp,
    input                      rsp_ready
);

    import ise_pkg::*;

    // ------------------------------
    // Handshake
    // ------------------------------

    logic accept;

    // A stalled response blocks the next request
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    // ------------------------------
    // Decode, register file, execute
    // ------------------------------

    ise_uop_t  uop;
    cpr_addr_t crd;
    word_t     crs1_data;
    word_t     crs2_data;
    word_t     crd_data;
    logic      exec_wen;
    word_t     exec_wdata;
    ise_resp_t exec_resp;

    assign crd = uop.rd[$bits(cpr_addr_t)-1:0];     // CPR dest is the low part of rd

    ise_decoder i_decoder (
        .insn_enc (req.insn_enc),
        .uop      (uop)
    );

    cpr_file i_cpr_file (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .raddr_a  (uop.crs1),
        .raddr_b  (uop.crs2),
        .raddr_c  (crd),
        .rdata_a  (crs1_data),
        .rdata_b  (crs2_data),
        .rdata_c  (crd_data),
        .wen      (exec_wen && accept),     // Write lands on the accept edge
        .waddr    (crd),
        .wdata    (exec_wdata)
    );

    ise_exec i_exec (
        .uop       (uop),
        .rs1       (req.rs1),
        .crs1_data (crs1_data),
        .crs2_data (crs2_data),
        .crd_data  (crd_data),
        .cpr_wen   (exec_wen),
        .cpr_wdata (exec_wdata),
        .resp      (exec_resp)
    );

    // ------------------------------
    // Response register
    // ------------------------------

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            rsp_valid <= 1'b0;
        end
        else if (accept)
        begin
            rsp_valid <= 1'b1;          // Valid exactly one cycle after accept
        end
        else if (rsp_ready)
        begin
            rsp_valid <= 1'b0;          // Drained, nothing new behind it
        end
    end

    // Payload only moves on accept, so it holds under back-pressure
    always_ff @(posedge g_clk)
    begin
        if (accept)
        begin
            rsp <= exec_resp;
        end
    end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic g_clk,
    output logic g_resetn
);

    // 4 ns period
    initial
    begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    // Reset held low over four rising edges, released on a falling edge
    initial
    begin
        g_resetn = 1'b0;
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
    end

endmodule

// ==== tests/ise_model.svh ====
`ifndef ISE_MODEL_SVH
`define ISE_MODEL_SVH

// Shadow of the sixteen CPRs, zero as after reset
word_t shadow [NUM_CPRS] = '{default: '0};

// Applies one accepted request to the shadow and returns the expected response
function automatic ise_resp_t model_step(input ise_req_t r);
    word_t     insn;
    word_t     a;
    word_t     b;
    word_t     d;
    word_t     res;
    cpr_addr_t crd;
    int        st;
    int        ln;
    ise_resp_t e;
    insn     = r.insn_enc;
    crd      = insn[10:7];
    a        = shadow[insn[19:16]];         // crs1
    b        = shadow[insn[23:20]];         // crs2
    d        = shadow[crd];
    st       = 2 * insn[27:24];             // Field counts pairs of bits
    ln       = 2 * insn[15:12];
    e        = '0;
    e.result = RES_SUCCESS;
    if (insn[6:0] != ISE_OPCODE || insn[31:28] > 4'd8)
    begin
        e.result = RES_DECODE_EXCEPTION;   // Nothing written
        return e;
    end
    res = '0;
    case (insn[31:28])
        OP_MV2GPR:
        begin
            e.rd_wen  = 1'b1;
            e.rd_addr = insn[11:7];
            e.rd_data = a;
        end
        OP_MV2COP: shadow[crd] = r.rs1;
        OP_CMOV:   if (b == 0) shadow[crd] = a;
        OP_CMOVN:  if (b != 0) shadow[crd] = a;
        OP_LUI:    shadow[crd] = {insn[27:12], d[15:0]};
        OP_LLI:    shadow[crd] = {d[31:16], insn[27:12]};
        OP_INS:
        begin
            for (int k = 0; k < 32; k++)
                res[k] = (k >= st && k < st + ln) ? a[k - st] : d[k];
            shadow[crd] = res;
        end
        OP_EXT:
        begin
            for (int k = 0; k < 32; k++)
                if (k < ln && k + st < 32)
                    res[k] = a[k + st];
            shadow[crd] = res;
        end
        default:                            // bop, table index is {crs1, crs2}
        begin
            for (int k = 0; k < 32; k++)
                res[k] = insn[24 + 2 * a[k] + b[k]];
            shadow[crd] = res;
        end
    endcase
    return e;
endfunction

`endif

// ==== tests/tb_ise.sv ====
`timescale 1ns/1ns

module tb_ise;

    import ise_pkg::*;

    `include "ise_model.svh"

    localparam int N_MOVE  = 16;
    localparam int N_COND  = 40;
    localparam int N_BIT   = 40;
    localparam int N_BAD   = 30;
    localparam int N_ORDER = 60;
    localparam int N_TOTAL = 3 * NUM_CPRS + 2 * N_MOVE + 3 * N_COND + 3 * N_BIT + N_BAD + N_ORDER;
    localparam int WATCHDOG_NS = (20 * N_TOTAL + 6) * 4;  // 20 cycles each plus reset

    logic      g_clk;
    logic      g_resetn;
    logic      req_valid;
    logic      req_ready;
    logic      rsp_valid;
    logic      rsp_ready;
    ise_req_t  req;
    ise_resp_t rsp;
    ise_resp_t exp_q [$];       // Expected responses in request order
    ise_resp_t exp_rsp;
    ise_resp_t held_rsp;
    logic      accepted_last;
    logic      held_last;
    int        errors;
    int        stall_pct;
    string     test_name;

    tb_clock i_clock (.g_clk(g_clk), .g_resetn(g_resetn));

    ise_top i_dut (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // Unused fields stay random, so immediates and tables come for free
    function automatic ise_req_t make_req(ise_op_e op, gpr_addr_t rd, cpr_addr_t c1,
                                          cpr_addr_t c2, word_t rs1);
        ise_req_t r;
        r.insn_enc        = $urandom;
        r.insn_enc[31:28] = op;
        r.insn_enc[23:20] = c2;
        r.insn_enc[19:16] = c1;
        r.insn_enc[11:7]  = rd;
        r.insn_enc[6:0]   = ISE_OPCODE;
        r.rs1             = rs1;
        return r;
    endfunction

    // Enters on a falling edge and leaves on the one after acceptance
    task automatic send(input ise_req_t r);
        repeat ($urandom_range(2)) @(negedge g_clk);   // Random idle gap
        req       = r;
        req_valid = 1'b1;
        @(posedge g_clk);
        while (!req_ready) @(posedge g_clk);
        @(negedge g_clk);
        req_valid = 1'b0;
    endtask

    task automatic sweep_cprs();
        for (int c = 0; c < NUM_CPRS; c++)
            send(make_req(OP_MV2GPR, gpr_addr_t'($urandom), cpr_addr_t'(c), 4'd0, $urandom));
    endtask

    // Back-pressure from the core side
    always @(negedge g_clk)
        rsp_ready = ($urandom_range(99) >= stall_pct);

    // ------------------------------
    // Response monitor
    // ------------------------------

    always @(posedge g_clk)
    begin
        if (g_resetn)
        begin
            if (accepted_last)
                assert (rsp_valid)
                else
                begin
                    errors++;
                    $display("Error %s: no response one cycle after accept", test_name);
                end
            if (held_last)
                assert (rsp === held_rsp)
                else
                begin
                    errors++;
                    $display("Fail %s: expected %h, actual %h", test_name, held_rsp, rsp);
                end
            assert (!(rsp_valid && !rsp_ready && req_ready))
            else
            begin
                errors++;
                $display("Error %s: request ready while response stalled", test_name);
            end
            if (rsp_valid && rsp_ready)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    errors++;
                    $display("Error %s: response with no request behind it", test_name);
                end
                if (exp_q.size() != 0)
                begin
                    exp_rsp = exp_q.pop_front();
                    assert (rsp === exp_rsp)
                    else
                    begin
                        errors++;
                        $display("Fail %s: expected %h, actual %h", test_name, exp_rsp, rsp);
                    end
                end
            end
            if (req_valid && req_ready)
                exp_q.push_back(model_step(req));   // Model sees requests in accept order
            accepted_last = req_valid && req_ready;
            held_last     = rsp_valid && !rsp_ready;
            held_rsp      = rsp;
        end
    end

    initial
    begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
        $display("Errors: %0d", errors + 1);
        $display("Errors found");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial
    begin
        cpr_addr_t c;
        cpr_addr_t c2;
        word_t     v;
        word_t     w;
        void'($urandom(32'h8c09));
        req_valid     = 1'b0;
        req           = '0;
        rsp_ready     = 1'b0;
        accepted_last = 1'b0;
        held_last     = 1'b0;
        stall_pct     = 25;
        @(posedge g_resetn);
        @(negedge g_clk);

        test_name = "reset_move";                   // CPRs read zero before any move
        sweep_cprs();
        repeat (N_MOVE)
        begin
            c = $urandom;
            send(make_req(OP_MV2COP, {1'b0, c}, 4'd0, 4'd0, $urandom));
            send(make_req(OP_MV2GPR, gpr_addr_t'($urandom), c, 4'd0, $urandom));
        end

        test_name = "cond_imm";
        repeat (N_COND)
        begin
            c  = $urandom;
            c2 = $urandom;
            v  = $urandom_range(1) ? 32'h0 : word_t'($urandom);    // Zero crs2 half the time
            send(make_req(OP_MV2COP, {1'b0, c2}, 4'd0, 4'd0, v));
            send(make_req(ise_op_e'(2 + $urandom_range(3)), {1'b0, c}, cpr_addr_t'($urandom),
                          c2, $urandom));           // cmov, cmovn, lui, lli
            send(make_req(OP_MV2GPR, gpr_addr_t'($urandom), c, 4'd0, $urandom));
        end

        test_name = "bitfield_lut";
        repeat (N_BIT)
        begin
            c  = $urandom;
            c2 = $urandom;
            send(make_req(OP_MV2COP, {1'b0, c2}, 4'd0, 4'd0, $urandom));
            send(make_req(ise_op_e'(6 + $urandom_range(2)), {1'b0, c}, c2,
                          cpr_addr_t'($urandom), $urandom));    // ins, ext, bop
            send(make_req(OP_MV2GPR, gpr_addr_t'($urandom), c, 4'd0, $urandom));
        end

        test_name = "decode_exc";
        sweep_cprs();                               // Snapshot before bad encodings
        repeat (N_BAD)
        begin
            w = $urandom;
            if ($urandom_range(1))
            begin
                if (w[6:0] == ISE_OPCODE)
                    w[0] = ~w[0];                   // Wrong major opcode
            end
            else
            begin
                w[6:0]   = ISE_OPCODE;
                w[31:28] = 4'(9 + $urandom_range(6));  // Reserved function code
            end
            send(ise_req_t'{insn_enc: w, rs1: $urandom});
        end
        sweep_cprs();

        test_name = "order_stall";
        stall_pct = 60;
        repeat (N_ORDER)
            send(make_req(ise_op_e'($urandom_range(8)), gpr_addr_t'($urandom),
                          cpr_addr_t'($urandom), cpr_addr_t'($urandom), $urandom));

        while (exp_q.size() != 0) @(negedge g_clk);
        repeat (2) @(negedge g_clk);
        assert (!rsp_valid)                         // Nothing may trail the last response
        else
        begin
            errors++;
            $display("Error: response still pending after the last one was taken");
        end
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
